/* ilv_top.f */
+incdir+hdl
hdl/ilv_data_pkg.sv
hdl/ilv_ctrl_pkg.sv
hdl/ilv_buf_if.sv
hdl/ilv_wb_writer.sv
hdl/ilv_bank_ctrl.sv
hdl/ilv_block_buffer.sv
hdl/ilv_wb_reader.sv
hdl/ilv_top.sv
bench/ilv_clk_gen.sv
bench/ilv_tb.sv

/* run.sh */
#!/bin/sh
# build the interleaver testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ilv_tb \
  -f ilv_top.f -o ilv_sim || exit 1
out=$(./obj_dir/ilv_sim)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1

/* bench/ilv_tb.sv */
//----------------------------------------
// block interleaver testbench
// random wishbone source and sink, model
// of transpose and tags, bus monitor
//----------------------------------------

`include "ilv_params.svh"

module ilv_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int rows    = 2**`ILV_ROW_W;
  localparam int cols    = 2**`ILV_COL_W;
  localparam int blk_len = rows * cols;       // 32 words
  localparam int blocks  = 12;
  localparam int n_words = blocks * blk_len;
  localparam int wdog_ns = n_words * (4 + 13) * 40 * 2;

  logic                  iclk;
  logic                  rst_n;
  logic                  in_cyc;
  logic                  in_stb;
  logic [`ILV_DAT_W-1:0] in_dat;
  logic                  in_ack;
  logic                  out_cyc;
  logic                  out_stb;
  logic [`ILV_DAT_W-1:0] out_dat;
  logic [`ILV_TAG_W-1:0] out_tag;
  logic                  out_ack;

  logic [`ILV_DAT_W-1:0] in_words [$];  // model, accepted words in order
  int in_cnt;                           // accepted on the input bus
  int out_cnt;                          // acked on the output bus
  int max_occ;                          // peak words in flight

  ilv_clk_gen clk_gen_i (.iclk(iclk), .rst_n(rst_n));

  ilv_top ilv_top_i (.*);   // port names match one to one

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input int exp_v, input int act_v);
    abort_run($sformatf("mismatch at %0t: %s expected 'h%0h, actual 'h%0h",
                        $time, sig, exp_v, act_v));
  endtask

  //----------------------------------------
  // input side, wishbone master
  //----------------------------------------

  task automatic send_word(input logic [`ILV_DAT_W-1:0] d);
    in_cyc <= 1'b1;
    in_stb <= 1'b1;
    in_dat <= d;                           // held until ack
    do @(negedge iclk); while (!in_ack);   // stalls while both banks full
    in_words.push_back(d);
    in_cnt++;
    @(posedge iclk);                       // transfer ends on this edge
  endtask

  task automatic feed_blocks();
    logic [`ILV_DAT_W-1:0] d;
    int gap;
    for (int i = 0; i < n_words; i++) begin
      d = $urandom;
      send_word(d);
      gap = $urandom % 4;
      if (gap != 0) begin
        in_cyc <= 1'b0;
        in_stb <= 1'b0;
        repeat (gap) @(posedge iclk);
      end
    end
    in_cyc <= 1'b0;
    in_stb <= 1'b0;
  endtask

  //----------------------------------------
  // output side, wishbone slave
  //----------------------------------------

  // payload and strobe must not move before ack
  task automatic check_held(input logic [`ILV_DAT_W-1:0] d, input logic [`ILV_TAG_W-1:0] t);
    assert (out_stb) else abort_run("out_stb dropped before out_ack");
    assert (out_dat == d) else report_mismatch("out_dat", d, out_dat);
    assert (out_tag == t) else report_mismatch("out_tag", t, out_tag);
  endtask

  task automatic take_word(input int hold);
    logic [`ILV_DAT_W-1:0] seen_dat;
    logic [`ILV_TAG_W-1:0] seen_tag;
    int blk;
    int pos;
    int src;
    blk = out_cnt / blk_len;
    pos = out_cnt % blk_len;                           // r + 4c on the output
    src = blk * blk_len + cols * (pos % rows) + pos / rows;  // 8r + c on the input
    do @(negedge iclk); while (!out_stb);
    assert (src < in_words.size())
      else abort_run("output word appeared before its input was accepted");
    assert (out_dat == in_words[src]) else report_mismatch("out_dat", in_words[src], out_dat);
    assert (out_tag == blk % 256) else report_mismatch("out_tag", blk % 256, out_tag);
    seen_dat = out_dat;
    seen_tag = out_tag;
    repeat (hold) begin
      @(negedge iclk);
      check_held(seen_dat, seen_tag);
    end
    @(posedge iclk);
    out_ack <= 1'b1;
    @(negedge iclk);
    check_held(seen_dat, seen_tag);
    @(posedge iclk);
    out_ack <= 1'b0;                       // ack for exactly one cycle
    out_cnt++;
  endtask

  task automatic drain_blocks();
    int hold;
    for (int j = 0; j < n_words; j++) begin
      hold = $urandom % 13;
      if (j % blk_len == 0 && (j / blk_len) % 4 == 1)
        hold = 140 + $urandom % 40;        // blocks 1, 5, 9 stall, banks fill
      else if ($urandom % 32 == 0)
        hold = 40 + $urandom % 20;
      take_word(hold);
    end
  endtask

  //----------------------------------------
  // monitor, reset and in-flight bound
  //----------------------------------------

  initial begin : bus_monitor
    logic ack_q;
    logic rst_q;
    int   occ;
    ack_q   = 1'b0;
    rst_q   = 1'b0;
    max_occ = 0;
    forever begin
      @(negedge iclk);
      if (!rst_n || !rst_q) begin          // in reset and first cycle out of it
        assert (!in_ack) else report_mismatch("in_ack", 0, in_ack);
        assert (!out_cyc) else report_mismatch("out_cyc", 0, out_cyc);
        assert (!out_stb) else report_mismatch("out_stb", 0, out_stb);
      end
      assert (!(in_ack && ack_q)) else abort_run("in_ack stayed high for two cycles");
      assert (!in_ack || in_stb) else abort_run("in_ack raised without in_stb");
      assert (out_cyc == out_stb) else report_mismatch("out_cyc", out_stb, out_cyc);
      occ = in_cnt - out_cnt;
      assert (occ <= 2 * blk_len + 1)
        else abort_run("more words in flight than two banks can hold");
      if (occ > max_occ)
        max_occ = occ;
      ack_q = in_ack;
      rst_q = rst_n;
    end
  end

  initial begin : watchdog
    #(wdog_ns);
    abort_run("timeout: output did not complete");
  end

  initial begin : main
    void'($urandom(32'hca20_0359));
    in_cyc  <= 1'b0;
    in_stb  <= 1'b0;
    in_dat  <= '0;
    out_ack <= 1'b0;
    in_cnt  = 0;
    out_cnt = 0;
    do @(negedge iclk); while (!rst_n);
    @(posedge iclk);
    fork
      feed_blocks();
      drain_blocks();
    join
    assert (max_occ >= 2 * blk_len) else abort_run("back-pressure never filled both banks");
    $display("TEST PASS");
    $finish;
  end

endmodule

/* bench/ilv_clk_gen.sv */
//----------------------------------------
// testbench clock and reset
// 40 ns clock, reset low for 8 cycles
//----------------------------------------

module ilv_clk_gen (
  output logic iclk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    iclk  = 1'b0;
    rst_n = 1'b0;               // active from time 0
    repeat (8) @(posedge iclk);
    rst_n <= 1'b1;              // released on the 8th rising edge
  end

  always #20 iclk = ~iclk;      // half of the 40 ns period

endmodule

/* hdl/ilv_top.sv */
//----------------------------------------
// two-bank block interleaver
// wishbone slave in, 4x8 transpose,
// wishbone master out with block tag
//----------------------------------------

`include "ilv_params.svh"

module ilv_top (
  input  logic                  iclk,
  input  logic                  rst_n,
  // input bus, wishbone slave
  input  logic                  in_cyc,
  input  logic                  in_stb,
  input  logic [`ILV_DAT_W-1:0] in_dat,
  output logic                  in_ack,
  // output bus, wishbone master
  output logic                  out_cyc,
  output logic                  out_stb,
  output logic [`ILV_DAT_W-1:0] out_dat,
  output logic [`ILV_TAG_W-1:0] out_tag,
  input  logic                  out_ack
);

  ilv_buf_if buf_if ();   // writer, buffer and reader share it

  //----------------------------------------
  // input side
  //----------------------------------------

  ilv_wb_writer writer_i (
    .iclk   (iclk),
    .rst_n  (rst_n),
    .in_cyc (in_cyc),
    .in_stb (in_stb),
    .in_dat (in_dat),
    .in_ack (in_ack),
    .buf_w  (buf_if)
  );

  // ping-pong storage
  ilv_block_buffer buffer_i (
    .iclk  (iclk),
    .rst_n (rst_n),
    .buf_s (buf_if)
  );

  //----------------------------------------
  // output side
  //----------------------------------------

  ilv_wb_reader reader_i (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .buf_r   (buf_if),
    .out_cyc (out_cyc),
    .out_stb (out_stb),
    .out_dat (out_dat),
    .out_tag (out_tag),
    .out_ack (out_ack)
  );

endmodule

/* hdl/ilv_wb_reader.sv */
//----------------------------------------
// interleaver output side
// column-major readout of a sealed bank,
// wishbone classic master with data + tag
//----------------------------------------

module ilv_wb_reader import ilv_data_pkg::*, ilv_ctrl_pkg::*; (
  input  logic      iclk,
  input  logic      rst_n,
  // block buffer
  ilv_buf_if.reader buf_r,
  // wishbone master
  output logic      out_cyc,
  output logic      out_stb,
  output ilv_word_t out_dat,
  output ilv_tag_t  out_tag,
  input  logic      out_ack
);

  rd_state_t state;

  ilv_row_t row;      // inner counter
  ilv_col_t col;      // outer counter
  ilv_row_t row_nxt;
  ilv_col_t col_nxt;
  ilv_row_t row_sel;
  ilv_col_t col_sel;

  logic done;         // word accepted by the sink
  logic last;         // bottom right corner of block

  assign done = (state == rd_offer) && out_ack;
  assign last = (row == '1) && (col == '1);

  //----------------------------------------
  // position in the block
  //----------------------------------------

  // walk down a column, then step right
  always_comb begin
    row_nxt = row + 1'b1;
    col_nxt = col;
    if (row == '1)
      col_nxt = col + 1'b1;   // both wrap to 0 after word 31
  end

  // look ahead on ack, so the ram is read before fetch
  assign row_sel = done ? row_nxt : row;
  assign col_sel = done ? col_nxt : col;

  // storage is row-major, row * 8 + col
  assign buf_r.raddr = {row_sel, col_sel};

  //----------------------------------------
  // read FSM
  //----------------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= rd_idle;
      row   <= '0;
      col   <= '0;
    end else begin
      case (state)
        rd_idle    : if (!buf_r.empty) state <= rd_fetch; // word 0 read this cycle
        rd_fetch   : state <= rd_offer;
        rd_offer   : begin
          if (out_ack) begin
            row   <= row_nxt;
            col   <= col_nxt;
            state <= last ? rd_release : rd_fetch;
          end
        end
        rd_release : state <= rd_idle;  // empty valid again next cycle
        default    : state <= rd_idle;
      endcase
    end
  end

  // bus payload, held through offer
  always_ff @(posedge iclk) begin
    if (state == rd_fetch) begin
      out_dat <= buf_r.rdat;
      out_tag <= buf_r.rtag;
    end
  end

  assign out_cyc   = (state == rd_offer);
  assign out_stb   = (state == rd_offer);
  assign buf_r.rel = (state == rd_release);   // one pulse per block

endmodule

/* hdl/ilv_block_buffer.sv */
//----------------------------------------
// two-bank block buffer
// data ram with one cycle read latency,
// per-bank tag ram and bank control
//----------------------------------------

`include "ilv_params.svh"

module ilv_block_buffer import ilv_data_pkg::*; (
  input  logic      iclk,
  input  logic      rst_n,
  ilv_buf_if.buffer buf_s
);

  localparam int depth    = 2**(`ILV_ADDR_W + `ILV_BNUM_W);  // 64 words
  localparam int bank_num = 2**`ILV_BNUM_W;

  ilv_bank_t wbank;   // bank being filled
  ilv_bank_t rbank;   // bank being drained

  //----------------------------------------
  // bank pointers
  //----------------------------------------

  ilv_bank_ctrl bank_ctrl_i (
    .iclk  (iclk),
    .rst_n (rst_n),
    .seal  (buf_s.seal),
    .rel   (buf_s.rel),
    .wbank (wbank),
    .rbank (rbank),
    .full  (buf_s.full),
    .empty (buf_s.empty)
  );

  //----------------------------------------
  // data ram
  //----------------------------------------

  ilv_word_t mem [depth];

  always_ff @(posedge iclk) begin
    if (buf_s.write)
      mem[{wbank, buf_s.waddr}] <= buf_s.wdat;
    buf_s.rdat <= mem[{rbank, buf_s.raddr}];  // registered read
  end

  //----------------------------------------
  // tag ram
  //----------------------------------------

  ilv_tag_t tram [bank_num];  // one block number per bank

  // stamped when the bank is sealed
  always_ff @(posedge iclk) begin
    if (buf_s.seal)
      tram[wbank] <= buf_s.wtag;
  end

  // async read, rbank only moves on release
  assign buf_s.rtag = tram[rbank];

endmodule

/* hdl/ilv_bank_ctrl.sv */
//----------------------------------------
// ping-pong bank control
// write/read bank pointers, sealed count,
// registered full and empty flags
//----------------------------------------

`include "ilv_params.svh"

module ilv_bank_ctrl import ilv_data_pkg::*; (
  input  logic      iclk,
  input  logic      rst_n,
  //
  input  logic      seal,   // writer closed its bank
  input  logic      rel,    // reader done with its bank
  //
  output ilv_bank_t wbank,
  output ilv_bank_t rbank,
  output logic      full,   // no free bank
  output logic      empty   // no sealed bank
);

  localparam int bank_num = 2**`ILV_BNUM_W;

  logic [`ILV_BNUM_W:0] cnt;      // sealed banks, 0..bank_num
  logic [`ILV_BNUM_W:0] cnt_nxt;

  always_comb begin
    case ({seal, rel})
      2'b10   : cnt_nxt = cnt + 1'b1;
      2'b01   : cnt_nxt = cnt - 1'b1;
      default : cnt_nxt = cnt;    // both or none, no change
    endcase
  end

  //----------------------------------------
  // pointers and flags
  //----------------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      wbank <= '0;
      rbank <= '0;
      cnt   <= '0;
      full  <= 1'b0;
      empty <= 1'b1;    // nothing sealed yet
    end else begin
      if (seal) wbank <= wbank + 1'b1;
      if (rel)  rbank <= rbank + 1'b1;
      cnt   <= cnt_nxt;
      // flags follow the event by one cycle
      full  <= (cnt_nxt == bank_num);
      empty <= (cnt_nxt == '0);
    end
  end

endmodule

/* hdl/ilv_wb_writer.sv */
//----------------------------------------
// interleaver input side
// wishbone classic slave, row-major write
// addresses, seals the bank on word 31
//----------------------------------------

module ilv_wb_writer import ilv_data_pkg::*, ilv_ctrl_pkg::*; (
  input  logic       iclk,
  input  logic       rst_n,
  // wishbone slave, write only
  input  logic       in_cyc,
  input  logic       in_stb,
  input  ilv_word_t  in_dat,
  output logic       in_ack,
  // block buffer
  ilv_buf_if.writer  buf_w
);

  wr_state_t state;
  ilv_addr_t addr;    // row-major position
  ilv_tag_t  blk;     // block number
  ilv_word_t dat_q;   // captured bus word

  logic take;         // transfer accepted this cycle

  assign take = (state == wr_idle) && in_cyc && in_stb && !buf_w.full;

  //----------------------------------------
  // ack FSM and counters
  //----------------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= wr_idle;
      addr  <= '0;
      blk   <= '0;
    end else begin
      case (state)
        wr_idle : if (take) state <= wr_ack;
        wr_ack  : begin
          state <= wr_idle;     // ack low again before next sample
          addr  <= addr + 1'b1; // wraps at end of block
          if (addr == '1)
            blk <= blk + 1'b1;  // next block number after seal
        end
        default : state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (take) dat_q <= in_dat;
  end

  // one-cycle ack, write pulse in the same cycle
  assign in_ack      = (state == wr_ack);
  assign buf_w.write = (state == wr_ack);
  assign buf_w.waddr = addr;
  assign buf_w.wdat  = dat_q;

  // last word of the block closes the bank
  assign buf_w.seal  = (state == wr_ack) && (addr == '1);
  assign buf_w.wtag  = blk;

endmodule

/* hdl/ilv_buf_if.sv */
//----------------------------------------
// block buffer port bundle
// write side, read side and bank flags
//----------------------------------------

interface ilv_buf_if import ilv_data_pkg::*; ();

  // write side
  logic      write;   // word strobe
  ilv_addr_t waddr;
  ilv_word_t wdat;
  logic      seal;    // block complete
  ilv_tag_t  wtag;

  // read side
  ilv_addr_t raddr;
  ilv_word_t rdat;    // one cycle after raddr
  ilv_tag_t  rtag;
  logic      rel;     // bank consumed

  // bank flags
  logic      full;    // no free bank
  logic      empty;   // no sealed bank

  modport writer (output write, waddr, wdat, seal, wtag, input full);

  modport reader (output raddr, rel, input rdat, rtag, empty);

  modport buffer (
    input  write, waddr, wdat, seal, wtag, raddr, rel,
    output rdat, rtag, full, empty
  );

endinterface

/* hdl/ilv_ctrl_pkg.sv */
//----------------------------------------
// block interleaver control types
// FSM state encodings of writer and reader
//----------------------------------------

package ilv_ctrl_pkg;

  // slave side, ack lasts one cycle
  typedef enum logic {
    wr_idle,    // wait for stb
    wr_ack      // ack and write the word
  } wr_state_t;

  // master side, column-major readout
  typedef enum logic [1:0] {
    rd_idle,    // wait for a sealed bank
    rd_fetch,   // ram read in flight
    rd_offer,   // stb high until ack
    rd_release  // hand the bank back
  } rd_state_t;

endpackage

/* hdl/ilv_data_pkg.sv */
//----------------------------------------
// block interleaver data path types
// vectors whose width carries a meaning
//----------------------------------------

`include "ilv_params.svh"

package ilv_data_pkg;

  // payload
  typedef logic [`ILV_DAT_W-1:0]  ilv_word_t;   // one data word
  typedef logic [`ILV_TAG_W-1:0]  ilv_tag_t;    // block number

  // buffer addressing
  typedef logic [`ILV_ADDR_W-1:0] ilv_addr_t;   // row-major word address in a bank
  typedef logic [`ILV_BNUM_W-1:0] ilv_bank_t;   // bank index

  // block position
  typedef logic [`ILV_ROW_W-1:0]  ilv_row_t;
  typedef logic [`ILV_COL_W-1:0]  ilv_col_t;

endpackage

/* hdl/ilv_params.svh */
//----------------------------------------
// block interleaver parameters
// block shape, word and tag widths, bank index
//----------------------------------------

`ifndef ILV_PARAMS_SVH
`define ILV_PARAMS_SVH

// block shape 4 rows x 8 columns
`define ILV_ROW_W   2
`define ILV_COL_W   3
`define ILV_ADDR_W  (`ILV_ROW_W + `ILV_COL_W)  // word address inside a bank

// payload
`define ILV_DAT_W   8   // data word
`define ILV_TAG_W   8   // block number

`define ILV_BNUM_W  1   // two banks, ping-pong

`endif
